// File: project.f
cpu_pkg.sv
decode_branch.sv
bht.sv
btb.sv
ras.sv
branch_predictor.sv
tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

dependencies: {}

sources:
  - cpu_pkg.sv
  - decode_branch.sv
  - bht.sv
  - btb.sv
  - ras.sv
  - branch_predictor.sv
  - target: test
    files:
      - tb_branch_predictor.sv

// File: tb_branch_predictor.sv
`timescale 1ns/10ps

module tb_branch_predictor import cpu_pkg::*; ();

localparam int BTB_SIZE = 4; // small, so round robin wraps quickly
localparam int BHT_SIZE = 64;
localparam int RAS_SIZE = 4;
localparam real HALF_PERIOD = 2.0;
localparam real SAMPLE_DELAY = 1.5; // just before the rising edge

localparam logic [5:0] OP_REGIMM = 6'd1;
localparam logic [5:0] OP_J      = 6'd2;
localparam logic [5:0] OP_JAL    = 6'd3;
localparam logic [5:0] OP_BEQ    = 6'd4;
localparam logic [5:0] OP_BLEZ   = 6'd6;
localparam uint32_t    FILL      = 32'hffff_ffff; // becomes a random addu
localparam virt_t      BHT_PC    = 32'h0000_3000;

typedef struct packed {
	virt_t                        pc;
	uint32_t [FETCH_NUM-1:0]      instr;
	logic [FETCH_NUM-1:0]         instr_valid;
	logic                         stall;
	logic                         flush;
	logic                         res_valid;
	virt_t                        res_pc;
	virt_t                        res_target;
	controlflow_t                 res_cf;
	logic                         res_taken;
	logic                         res_mispredict;
	logic                         exp_valid;
	virt_t                        exp_vaddr;
	controlflow_t [FETCH_NUM-1:0] exp_cf;
	logic [FETCH_NUM-1:0]         exp_mj;
} vec_t;

logic                         clk, rst, flush, stall_s1;
virt_t                        pc;
uint32_t [FETCH_NUM-1:0]      instr;
logic [FETCH_NUM-1:0]         instr_valid;
logic                         res_valid, res_taken, res_mispredict;
virt_t                        res_pc, res_target;
controlflow_t                 res_cf;
logic                         valid;
virt_t                        predict_vaddr;
logic [FETCH_NUM-1:0]         maybe_jump;
controlflow_t [FETCH_NUM-1:0] cf;

vec_t         vecs[$];
string        names[$];
vec_t         pending;        // resolved-branch fields for the next row
counter_t     bht_cnt;        // reference model of the trained entry
logic         bht_trained;
integer       seed;
int           cycles;
int           timeout_limit = 20;

branch_predictor #(
	.BTB_SIZE ( BTB_SIZE ),
	.BHT_SIZE ( BHT_SIZE ),
	.RAS_SIZE ( RAS_SIZE )
) UUT (
	.clk, .rst, .flush, .stall_s1, .pc, .instr, .instr_valid,
	.res_valid, .res_pc, .res_target, .res_cf, .res_taken, .res_mispredict,
	.valid, .predict_vaddr, .maybe_jump, .cf
);

always #HALF_PERIOD clk = ~clk;

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= timeout_limit) begin
		$display("timeout: the stimulus table did not finish within %0d cycles", timeout_limit);
		$display("test failed");
		$fatal(1, "run aborted");
	end
end

function automatic uint32_t enc_branch(logic [5:0] op, logic [4:0] rt, logic [15:0] off);
	return {op, 5'd4, rt, off};
endfunction

function automatic uint32_t enc_jump(logic [5:0] op, logic [25:0] index);
	return {op, index};
endfunction

function automatic uint32_t enc_jr(logic [4:0] rs);
	return {6'd0, rs, 15'd0, 6'b001000};
endfunction

function automatic uint32_t enc_jalr(logic [4:0] rs);
	return {6'd0, rs, 5'd0, 5'd31, 5'd0, 6'b001001}; // link in $ra
endfunction

function automatic uint32_t filler_word();
	logic [4:0] rs, rt, rd;
	rs = 5'($random(seed));
	rt = 5'($random(seed));
	rd = 5'($random(seed));
	return {6'd0, rs, rt, rd, 5'd0, 6'b100001}; // addu
endfunction

// offset counts words from the delay slot
function automatic virt_t br_target(virt_t base, int slot, logic [15:0] off);
	return base + 4 * slot + {{14{off[15]}}, off, 2'b00} + 4;
endfunction

function automatic virt_t j_target(virt_t base, logic [25:0] index);
	return {base[31:28], index, 2'b00};
endfunction

function automatic virt_t link_addr(virt_t base, int slot);
	return base + 4 * slot + 8;
endfunction

task automatic report(input virt_t rpc, input virt_t rtgt, input controlflow_t rcf,
	input logic rtaken, input logic rmis);
	pending.res_valid      = 1'b1;
	pending.res_pc         = rpc;
	pending.res_target     = rtgt;
	pending.res_cf         = rcf;
	pending.res_taken      = rtaken;
	pending.res_mispredict = rmis;
endtask

task automatic add_vec(input string name, input virt_t vpc, input uint32_t w0, input uint32_t w1,
	input logic [1:0] iv, input logic stl, input logic fls, input logic e_valid,
	input virt_t e_vaddr, input controlflow_t e_cf0, input controlflow_t e_cf1,
	input logic [1:0] e_mj);
	vec_t v;
	v             = pending;
	v.pc          = vpc;
	v.instr       = {w1, w0};
	v.instr_valid = iv;
	v.stall       = stl;
	v.flush       = fls;
	v.exp_valid   = e_valid;
	v.exp_vaddr   = e_vaddr;
	v.exp_cf      = {e_cf1, e_cf0};
	v.exp_mj      = e_mj;
	vecs.push_back(v);
	names.push_back(name);
	pending = '0;
endtask

// expected prediction follows the saturating counter model
task automatic add_bht_row(input string name, input logic reported, input logic outcome);
	logic predict;
	predict = bht_trained ? (bht_cnt >= 2'd2) : 1'b1; // untrained, backward
	if (reported)
		report(BHT_PC, 32'h0, ControlFlow_Branch, outcome, 1'b0);
	add_vec(name, BHT_PC, enc_branch(OP_BEQ, 5'd5, 16'hfffc), FILL, 2'b11, 0, 0, predict,
		br_target(BHT_PC, 0, 16'hfffc), predict ? ControlFlow_Branch : ControlFlow_None,
		ControlFlow_None, 2'b01);
	if (reported) begin
		if (!bht_trained)
			bht_cnt = outcome ? 2'd3 : 2'd0;
		else if (outcome && bht_cnt != 2'd3)
			bht_cnt = bht_cnt + 2'd1;
		else if (!outcome && bht_cnt != 2'd0)
			bht_cnt = bht_cnt - 2'd1;
		bht_trained = 1'b1;
	end
endtask

task automatic build_table();
	virt_t p;
	p = 32'h0000_1000;
	add_vec("static_back", p, enc_branch(OP_BEQ, 5'd5, 16'hfffc), FILL, 2'b11, 0, 0,
		1, br_target(p, 0, 16'hfffc), ControlFlow_Branch, ControlFlow_None, 2'b01);
	p = 32'h0000_1100;
	add_vec("static_back_slot1", p, FILL, enc_branch(OP_REGIMM, 5'd1, 16'hfff8), 2'b11, 0, 0,
		1, br_target(p, 1, 16'hfff8), ControlFlow_None, ControlFlow_Branch, 2'b10);
	add_vec("static_fwd", 32'h0000_1200, enc_branch(OP_BEQ, 5'd5, 16'h0010), FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b01);
	p = 32'h3000_1300;
	add_vec("jump_j", p, FILL, enc_jump(OP_J, 26'h012_3456), 2'b11, 0, 0,
		1, j_target(p, 26'h012_3456), ControlFlow_None, ControlFlow_JumpImm, 2'b10);
	p = 32'h0000_1400;
	add_vec("branch_beats_jump", p, enc_branch(OP_BLEZ, 5'd0, 16'hfffe),
		enc_jump(OP_J, 26'h000_0040), 2'b11, 0, 0,
		1, br_target(p, 0, 16'hfffe), ControlFlow_Branch, ControlFlow_JumpImm, 2'b11);
	add_vec("invalid_ignored", 32'h0000_1500, enc_jump(OP_J, 26'h000_0040), FILL, 2'b10, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b00);
	// call and return
	p = 32'h0000_2000;
	add_vec("call_slot1", p, FILL, enc_jump(OP_JAL, 26'h000_0900), 2'b11, 0, 0,
		1, j_target(p, 26'h000_0900), ControlFlow_None, ControlFlow_JumpImm, 2'b10);
	add_vec("return_1", 32'h0000_2100, enc_jr(5'd31), FILL, 2'b11, 0, 0,
		1, link_addr(32'h0000_2000, 1), ControlFlow_Return, ControlFlow_None, 2'b01);
	p = 32'h0000_2200;
	add_vec("call_outer", p, enc_jump(OP_JAL, 26'h000_0a00), FILL, 2'b11, 0, 0,
		1, j_target(p, 26'h000_0a00), ControlFlow_JumpImm, ControlFlow_None, 2'b01);
	add_vec("call_inner_jalr", 32'h0000_2300, FILL, enc_jalr(5'd9), 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b10); // btb still empty
	add_vec("return_inner", 32'h0000_2400, enc_jr(5'd31), FILL, 2'b11, 0, 0,
		1, link_addr(32'h0000_2300, 1), ControlFlow_Return, ControlFlow_None, 2'b01);
	add_vec("return_outer", 32'h0000_2500, FILL, enc_jr(5'd31), 2'b11, 0, 0,
		1, link_addr(32'h0000_2200, 0), ControlFlow_None, ControlFlow_Return, 2'b10);
	p = 32'h0000_2600;
	add_vec("call_before_stall", p, enc_jump(OP_JAL, 26'h000_0b00), FILL, 2'b11, 0, 0,
		1, j_target(p, 26'h000_0b00), ControlFlow_JumpImm, ControlFlow_None, 2'b01);
	p = 32'h0000_2700;
	add_vec("stalled_call", p, FILL, enc_jump(OP_JAL, 26'h000_0c00), 2'b11, 1, 0,
		1, j_target(p, 26'h000_0c00), ControlFlow_None, ControlFlow_JumpImm, 2'b10);
	add_vec("return_skips_stalled", 32'h0000_2800, enc_jr(5'd31), FILL, 2'b11, 0, 0,
		1, link_addr(32'h0000_2600, 0), ControlFlow_Return, ControlFlow_None, 2'b01);
	p = 32'h0000_2900;
	add_vec("call_before_flush", p, enc_jump(OP_JAL, 26'h000_0d00), FILL, 2'b11, 0, 0,
		1, j_target(p, 26'h000_0d00), ControlFlow_JumpImm, ControlFlow_None, 2'b01);
	add_vec("flush", 32'h0000_2a00, FILL, FILL, 2'b11, 0, 1,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b00);
	add_vec("return_after_flush", 32'h0000_2b00, enc_jr(5'd31), FILL, 2'b11, 0, 0,
		1, 32'h0, ControlFlow_Return, ControlFlow_None, 2'b01);
	// history training on one backward branch
	add_bht_row("bht_nt_1", 1, 0);
	add_bht_row("bht_nt_2", 1, 0);
	add_bht_row("bht_t_1", 1, 1);
	add_bht_row("bht_t_2", 1, 1);
	add_bht_row("bht_restored", 0, 0);
	// register jumps, trained only on a mispredict
	report(32'h0000_4000, 32'h0000_5550, ControlFlow_JumpReg, 1, 1);
	add_vec("btb_miss", 32'h0000_4000, enc_jr(5'd5), FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b01);
	report(32'h0000_4104, 32'h0000_5660, ControlFlow_JumpReg, 1, 1);
	add_vec("btb_hit", 32'h0000_4000, enc_jr(5'd5), FILL, 2'b11, 0, 0,
		1, 32'h0000_5550, ControlFlow_JumpReg, ControlFlow_None, 2'b01);
	report(32'h0000_4200, 32'h0000_5770, ControlFlow_JumpReg, 1, 1);
	add_vec("btb_train_3", 32'h0000_4800, FILL, FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b00);
	report(32'h0000_4300, 32'h0000_5880, ControlFlow_JumpReg, 1, 1);
	add_vec("btb_train_4", 32'h0000_4800, FILL, FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b00);
	report(32'h0000_4400, 32'h0000_5990, ControlFlow_JumpReg, 1, 1); // wraps onto entry 0
	add_vec("btb_train_5", 32'h0000_4800, FILL, FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b00);
	add_vec("btb_newest", 32'h0000_4400, enc_jr(5'd6), FILL, 2'b11, 0, 0,
		1, 32'h0000_5990, ControlFlow_JumpReg, ControlFlow_None, 2'b01);
	add_vec("btb_evicted", 32'h0000_4000, enc_jr(5'd5), FILL, 2'b11, 0, 0,
		0, 32'h0, ControlFlow_None, ControlFlow_None, 2'b01);
	add_vec("btb_kept_slot1", 32'h0000_4100, FILL, enc_jr(5'd7), 2'b11, 0, 0,
		1, 32'h0000_5660, ControlFlow_None, ControlFlow_JumpReg, 2'b10);
endtask

task automatic apply_vec(input vec_t v);
	pc = v.pc;
	for (int i = 0; i < FETCH_NUM; i++)
		instr[i] = (v.instr[i] == FILL) ? filler_word() : v.instr[i];
	instr_valid    = v.instr_valid;
	stall_s1       = v.stall;
	flush          = v.flush;
	res_valid      = v.res_valid;
	res_pc         = v.res_pc;
	res_target     = v.res_target;
	res_cf         = v.res_cf;
	res_taken      = v.res_taken;
	res_mispredict = v.res_mispredict;
endtask

task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
	if (actual !== expected) begin
		$display("error: %s expected %h actual %h", what, expected, actual);
		$display("test failed");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

task automatic check_outputs(input int n);
	vec_t v;
	v = vecs[n];
	check({names[n], " valid"}, 32'(v.exp_valid), 32'(valid));
	if (v.exp_valid)
		check({names[n], " predict_vaddr"}, v.exp_vaddr, predict_vaddr);
	for (int i = 0; i < FETCH_NUM; i++)
		check($sformatf("%s cf[%0d]", names[n], i), 32'(v.exp_cf[i]), 32'(cf[i]));
	check({names[n], " maybe_jump"}, 32'(v.exp_mj), 32'(maybe_jump));
endtask

initial begin
	seed           = 32'h59aa;
	cycles         = 0;
	clk            = 1'b0;
	rst            = 1'b1;
	flush          = 1'b0;
	stall_s1       = 1'b0;
	pc             = '0;
	instr          = '0;
	instr_valid    = '0;
	res_valid      = 1'b0;
	res_pc         = '0;
	res_target     = '0;
	res_cf         = ControlFlow_None;
	res_taken      = 1'b0;
	res_mispredict = 1'b0;
	pending        = '0;
	bht_cnt        = 2'd0;
	bht_trained    = 1'b0;

	build_table();
	timeout_limit = 4 * vecs.size() + 20;

	repeat (2) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;

	for (int n = 0; n < vecs.size(); n++) begin
		@(negedge clk);
		apply_vec(vecs[n]);
		#SAMPLE_DELAY;
		check_outputs(n);
	end

	@(negedge clk);
	instr_valid = '0;
	res_valid   = 1'b0;
	stall_s1    = 1'b0;
	flush       = 1'b0;
	@(negedge clk);

	$display("test passed");
	$finish;
end

endmodule

// File: branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor import cpu_pkg::*; #(
	parameter int BTB_SIZE = 8,
	parameter int BHT_SIZE = 1024,
	parameter int RAS_SIZE = 8
)(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush,
	input  logic                           stall_s1,

	input  virt_t                          pc,    // 8-byte aligned
	input  uint32_t      [FETCH_NUM-1:0]   instr,
	input  logic         [FETCH_NUM-1:0]   instr_valid,

	// resolved branch from execute
	input  logic                           res_valid,
	input  virt_t                          res_pc,
	input  virt_t                          res_target,
	input  controlflow_t                   res_cf,
	input  logic                           res_taken,
	input  logic                           res_mispredict,

	output logic                           valid,
	output virt_t                          predict_vaddr,
	output logic         [FETCH_NUM-1:0]   maybe_jump,
	output controlflow_t [FETCH_NUM-1:0]   cf
);

// table updates
logic  bht_update_valid, bht_update_taken;
virt_t bht_update_pc;
logic  btb_update_valid;
virt_t btb_update_pc, btb_update_target;

// table lookups
logic  [FETCH_NUM-1:0] bht_hit, bht_taken;
logic  [FETCH_NUM-1:0] btb_hit;
virt_t [FETCH_NUM-1:0] btb_target;
logic                  ras_valid;
virt_t                 ras_data;
logic                  ras_push, ras_pop;
virt_t                 ras_push_data;

// per-slot decode
uint32_t [FETCH_NUM-1:0] imm_branch, imm_jump;
logic    [FETCH_NUM-1:0] dec_branch, dec_return, dec_call, dec_jump_i, dec_jump_r;
logic    [FETCH_NUM-1:0] is_branch, is_return, is_call, is_jump_i, is_jump_r;
logic    [FETCH_NUM-1:0] static_back, br_taken;
virt_t   [FETCH_NUM-1:0] slot_pc;

for (genvar i = 0; i < FETCH_NUM; i++) begin : gen_slot
	decode_branch dec_inst (
		.instr      ( instr[i]      ),
		.imm_branch ( imm_branch[i] ),
		.imm_jump   ( imm_jump[i]   ),
		.is_branch  ( dec_branch[i] ),
		.is_return  ( dec_return[i] ),
		.is_call    ( dec_call[i]   ),
		.is_jump_i  ( dec_jump_i[i] ),
		.is_jump_r  ( dec_jump_r[i] )
	);

	assign slot_pc[i] = pc + virt_t'(4 * i);

	assign is_branch[i] = instr_valid[i] & dec_branch[i];
	assign is_return[i] = instr_valid[i] & dec_return[i];
	assign is_call[i]   = instr_valid[i] & dec_call[i];
	assign is_jump_i[i] = instr_valid[i] & dec_jump_i[i];
	assign is_jump_r[i] = instr_valid[i] & dec_jump_r[i];

	assign maybe_jump[i] = instr_valid[i] & (dec_branch[i] | dec_return[i]
		| dec_call[i] | dec_jump_i[i] | dec_jump_r[i]);

	// negative offset, including a branch to itself
	assign static_back[i] = imm_branch[i][31] | (imm_branch[i] == '0);
	assign br_taken[i]    = bht_hit[i] ? bht_taken[i] : static_back[i];
end

// lowest slot is scanned last and wins
always_comb begin
	ras_push      = 1'b0;
	ras_pop       = 1'b0;
	ras_push_data = '0;
	predict_vaddr = '0;
	for (int i = 0; i < FETCH_NUM; i++)
		cf[i] = ControlFlow_None;

	for (int i = FETCH_NUM - 1; i >= 0; i--) begin
		unique case ({is_branch[i], is_return[i], is_jump_i[i], is_jump_r[i]})
			4'b0000: ;
			4'b0001: begin
				ras_push = 1'b0;
				ras_pop  = 1'b0;
				if (btb_hit[i]) begin // no guess without a trained entry
					cf[i]         = ControlFlow_JumpReg;
					predict_vaddr = btb_target[i];
				end
			end
			4'b0010: begin
				ras_push      = 1'b0;
				ras_pop       = 1'b0;
				cf[i]         = ControlFlow_JumpImm;
				predict_vaddr = {pc[31:28], imm_jump[i][27:0]};
			end
			4'b0100: begin
				ras_push      = 1'b0;
				ras_pop       = ras_valid;
				cf[i]         = ControlFlow_Return;
				predict_vaddr = ras_valid ? ras_data : '0;
			end
			4'b1000: begin
				ras_push = 1'b0;
				ras_pop  = 1'b0;
				if (br_taken[i]) begin
					cf[i]         = ControlFlow_Branch;
					predict_vaddr = slot_pc[i] + imm_branch[i];
				end
			end
			default: ;
		endcase

		if (is_call[i]) begin
			ras_push      = 1'b1;
			ras_push_data = slot_pc[i] + 32'd8; // skip the delay slot
		end
	end

	valid = 1'b0;
	for (int i = 0; i < FETCH_NUM; i++)
		valid = valid | (cf[i] != ControlFlow_None);
end

// training from execute, never stalled
assign bht_update_valid = res_valid & (res_cf == ControlFlow_Branch);
assign bht_update_pc    = res_pc;
assign bht_update_taken = res_taken;

assign btb_update_valid  = res_valid & res_mispredict & (res_cf == ControlFlow_JumpReg);
assign btb_update_pc     = res_pc;
assign btb_update_target = res_target;

bht #(
	.ENTRIES_NUM ( BHT_SIZE )
) bht_inst (
	.clk,
	.rst,
	.pc,
	.update_valid ( bht_update_valid ),
	.update_taken ( bht_update_taken ),
	.update_pc    ( bht_update_pc    ),
	.hit          ( bht_hit          ),
	.taken        ( bht_taken        )
);

btb #(
	.ENTRIES_NUM ( BTB_SIZE )
) btb_inst (
	.clk,
	.rst,
	.pc,
	.update_valid  ( btb_update_valid  ),
	.update_pc     ( btb_update_pc     ),
	.update_target ( btb_update_target ),
	.hit           ( btb_hit           ),
	.target        ( btb_target        )
);

ras #(
	.ENTRIES_NUM ( RAS_SIZE )
) ras_inst (
	.clk,
	.rst,
	.flush,
	.push_req  ( ~stall_s1 & ras_push ),
	.pop_req   ( ~stall_s1 & ras_pop  ),
	.push_data ( ras_push_data        ),
	.ras_valid ( ras_valid            ),
	.ras_data  ( ras_data             )
);

endmodule

// File: ras.sv
`timescale 1ns/10ps

module ras import cpu_pkg::*; #(
	parameter int ENTRIES_NUM = 8
)(
	input  logic  clk,
	input  logic  rst,
	input  logic  flush,
	input  logic  push_req,
	input  logic  pop_req,
	input  virt_t push_data,
	output logic  ras_valid,
	output virt_t ras_data
);

localparam int PTR_W = (ENTRIES_NUM > 1) ? $clog2(ENTRIES_NUM) : 1;
localparam int CNT_W = $clog2(ENTRIES_NUM + 1);

virt_t            stack [ENTRIES_NUM];
logic [PTR_W-1:0] tos;      // index of the top entry
logic [PTR_W-1:0] tos_inc, tos_dec;
logic [CNT_W-1:0] count;    // saturates, oldest lost on overflow

assign tos_inc = (tos == PTR_W'(ENTRIES_NUM - 1)) ? '0 : tos + 1'b1;
assign tos_dec = (tos == '0) ? PTR_W'(ENTRIES_NUM - 1) : tos - 1'b1;

assign ras_valid = (count != '0);
assign ras_data  = stack[tos];

always_ff @(posedge clk) begin
	if (push_req && !flush)
		stack[tos_inc] <= push_data;
end

always_ff @(posedge clk) begin
	if (rst || flush) begin
		tos   <= '0;
		count <= '0;
	end else if (push_req) begin
		tos <= tos_inc;
		if (count != CNT_W'(ENTRIES_NUM))
			count <= count + 1'b1;
	end else if (pop_req && ras_valid) begin // empty pop ignored
		tos   <= tos_dec;
		count <= count - 1'b1;
	end
end

// predictor picks one slot per cycle for the stack
push_pop_excl: assert property (@(posedge clk) disable iff (rst)
	!(push_req && pop_req));

endmodule

// File: btb.sv
`timescale 1ns/10ps

module btb import cpu_pkg::*; #(
	parameter int ENTRIES_NUM = 8
)(
	input  logic                  clk,
	input  logic                  rst,
	input  virt_t                 pc,
	input  logic                  update_valid,
	input  virt_t                 update_pc,
	input  virt_t                 update_target,
	output logic  [FETCH_NUM-1:0] hit,
	output virt_t [FETCH_NUM-1:0] target
);

localparam int PTR_W = (ENTRIES_NUM > 1) ? $clog2(ENTRIES_NUM) : 1;

typedef logic [29:0] tag_t; // full word address

tag_t                   tag [ENTRIES_NUM];
virt_t                  tgt [ENTRIES_NUM];
logic [ENTRIES_NUM-1:0] entry_valid;
logic [PTR_W-1:0]       rr_ptr;      // next victim
logic [PTR_W-1:0]       match_way, upd_way;
logic                   upd_match;
logic                   dup_tag;

always_comb begin
	hit    = '0;
	target = '0;
	for (int i = 0; i < FETCH_NUM; i++) begin
		for (int e = 0; e < ENTRIES_NUM; e++) begin
			if (entry_valid[e] && tag[e] == pc[31:2] + 30'(i)) begin
				hit[i]    = 1'b1;
				target[i] = tgt[e];
			end
		end
	end
end

// existing entry is refreshed in place
always_comb begin
	upd_match = 1'b0;
	match_way = '0;
	for (int e = 0; e < ENTRIES_NUM; e++) begin
		if (entry_valid[e] && tag[e] == update_pc[31:2]) begin
			upd_match = 1'b1;
			match_way = PTR_W'(e);
		end
	end
	upd_way = upd_match ? match_way : rr_ptr;
end

always_ff @(posedge clk) begin
	if (update_valid) begin
		tag[upd_way] <= update_pc[31:2];
		tgt[upd_way] <= update_target;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		entry_valid <= '0;
		rr_ptr      <= '0;
	end else if (update_valid) begin
		entry_valid[upd_way] <= 1'b1;
		if (!upd_match)
			rr_ptr <= (rr_ptr == PTR_W'(ENTRIES_NUM - 1)) ? '0 : rr_ptr + 1'b1;
	end
end

always_comb begin
	dup_tag = 1'b0;
	for (int a = 0; a < ENTRIES_NUM; a++)
		for (int b = a + 1; b < ENTRIES_NUM; b++)
			dup_tag |= entry_valid[a] && entry_valid[b] && tag[a] == tag[b];
end

tag_unique: assert property (@(posedge clk) disable iff (rst) !dup_tag);

endmodule

// File: bht.sv
`timescale 1ns/10ps

module bht import cpu_pkg::*; #(
	parameter int ENTRIES_NUM = 1024
)(
	input  logic                 clk,
	input  logic                 rst,
	input  virt_t                pc,
	input  logic                 update_valid,
	input  logic                 update_taken,
	input  virt_t                update_pc,
	output logic [FETCH_NUM-1:0] hit,
	output logic [FETCH_NUM-1:0] taken
);

localparam int IDX_W = (ENTRIES_NUM > 1) ? $clog2(ENTRIES_NUM) : 1;

typedef logic [IDX_W-1:0] index_t;

counter_t               cnt [ENTRIES_NUM];
logic [ENTRIES_NUM-1:0] entry_valid;
index_t                 upd_idx;
counter_t               upd_cnt;

function automatic index_t to_index(logic [29:0] word_addr);
	return index_t'(word_addr % ENTRIES_NUM);
endfunction

// one read port per slot
always_comb begin
	for (int i = 0; i < FETCH_NUM; i++) begin
		hit[i]   = entry_valid[to_index(pc[31:2] + 30'(i))];
		taken[i] = cnt[to_index(pc[31:2] + 30'(i))] >= CNT_WEAK_T;
	end
end

always_comb begin
	upd_idx = to_index(update_pc[31:2]);
	if (!entry_valid[upd_idx])
		upd_cnt = update_taken ? CNT_STRONG_T : CNT_STRONG_NT; // first sighting
	else if (update_taken)
		upd_cnt = (cnt[upd_idx] == CNT_STRONG_T) ? CNT_STRONG_T : cnt[upd_idx] + 2'd1;
	else
		upd_cnt = (cnt[upd_idx] == CNT_STRONG_NT) ? CNT_STRONG_NT : cnt[upd_idx] - 2'd1;
end

always_ff @(posedge clk) begin
	if (update_valid)
		cnt[upd_idx] <= upd_cnt;
end

always_ff @(posedge clk) begin
	if (rst)
		entry_valid <= '0;
	else if (update_valid)
		entry_valid[upd_idx] <= 1'b1;
end

// execute only reports instruction addresses
upd_aligned: assert property (@(posedge clk) disable iff (rst)
	update_valid |-> update_pc[1:0] == 2'b00);

endmodule

// File: decode_branch.sv
`timescale 1ns/10ps

module decode_branch import cpu_pkg::*; (
	input  uint32_t instr,
	output uint32_t imm_branch,
	output uint32_t imm_jump,
	output logic    is_branch,
	output logic    is_return,
	output logic    is_call,
	output logic    is_jump_i,
	output logic    is_jump_r
);

localparam logic [5:0] OP_SPECIAL = 6'b000000;
localparam logic [5:0] OP_REGIMM  = 6'b000001;
localparam logic [5:0] OP_J       = 6'b000010;
localparam logic [5:0] OP_JAL     = 6'b000011;
localparam logic [5:0] OP_BEQ     = 6'b000100;
localparam logic [5:0] OP_BNE     = 6'b000101;
localparam logic [5:0] OP_BLEZ    = 6'b000110;
localparam logic [5:0] OP_BGTZ    = 6'b000111;
localparam logic [5:0] FN_JR      = 6'b001000;
localparam logic [5:0] FN_JALR    = 6'b001001;
localparam logic [4:0] RT_BLTZ    = 5'b00000;
localparam logic [4:0] RT_BGEZ    = 5'b00001;

logic [5:0] opcode, funct;
logic [4:0] rs, rt;

assign opcode = instr[31:26];
assign rs     = instr[25:21];
assign rt     = instr[20:16];
assign funct  = instr[5:0];

always_comb begin
	is_branch = 1'b0;
	is_return = 1'b0;
	is_call   = 1'b0;
	is_jump_i = 1'b0;
	is_jump_r = 1'b0;
	case (opcode)
		OP_SPECIAL: begin
			if (funct == FN_JR) begin
				is_return = (rs == 5'd31); // jr $ra
				is_jump_r = (rs != 5'd31);
			end else if (funct == FN_JALR) begin
				is_jump_r = 1'b1;
				is_call   = 1'b1;
			end
		end
		OP_REGIMM: is_branch = (rt == RT_BLTZ) || (rt == RT_BGEZ);
		OP_J:      is_jump_i = 1'b1;
		OP_JAL: begin
			is_jump_i = 1'b1;
			is_call   = 1'b1;
		end
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: is_branch = 1'b1;
		default: ;
	endcase
end

// offset is relative to the delay slot
assign imm_branch = {{14{instr[15]}}, instr[15:0], 2'b00} + 32'd4;
assign imm_jump   = {4'b0000, instr[25:0], 2'b00}; // region bits added by caller

flag_onehot: assert final ($onehot0({is_branch, is_return, is_jump_i, is_jump_r}));

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

// fetch group width
localparam int FETCH_NUM = 2;

typedef logic [31:0] virt_t;   // virtual address
typedef logic [31:0] uint32_t; // instruction word or offset

// bimodal history state
typedef logic [1:0] counter_t;

localparam counter_t CNT_STRONG_NT = 2'd0;
localparam counter_t CNT_WEAK_T    = 2'd2; // lowest taken state
localparam counter_t CNT_STRONG_T  = 2'd3;

// control-flow class of one fetch slot
typedef enum logic [2:0] {
	ControlFlow_None,
	ControlFlow_Branch,   // conditional, history or static
	ControlFlow_JumpImm,  // j / jal
	ControlFlow_JumpReg,  // jr / jalr through the target buffer
	ControlFlow_Return    // jr $31 through the return stack
} controlflow_t;

endpackage
